/* bubble_timing_gen.sv */
`timescale 1ns/1ns

module bubble_timing_gen
(
    input  logic MCLK,      // 48 MHz master clock
    input  logic reset,
    input  logic en_n,
    input  logic bss_n,
    input  logic bsen_n,
    input  logic repen_n,
    input  logic booten_n,
    input  logic swapen_n,
    output logic clkout,    // 4 MHz
    output ftg_access_pkg::access_state_t access_type,
    output bubble_timing_pkg::cycle_num_t bout_cycle_num,
    output logic bin_clk_en_n,
    output logic bout_clk_en_n,
    output bubble_timing_pkg::abs_pos_t   abs_pos
);

    import bubble_timing_pkg::*;
    import ftg_access_pkg::*;

    logic          sample_strobe;  // divider to decode
    access_state_t access_state;   // decode to rotation and result
    rot_count_t    rot_count;      // rotation to result

    assign access_type = access_state;

    ftg_clock_divider ftg_clock_divider_i
    (
        .MCLK          (MCLK),
        .reset         (reset),
        .clkout        (clkout),
        .sample_strobe (sample_strobe)
    );

    ftg_access_decode ftg_access_decode_i
    (
        .MCLK          (MCLK),
        .reset         (reset),
        .sample_strobe (sample_strobe),
        .en_n          (en_n),
        .bss_n         (bss_n),
        .bsen_n        (bsen_n),
        .repen_n       (repen_n),
        .booten_n      (booten_n),
        .swapen_n      (swapen_n),
        .access_type   (access_state)
    );

    ftg_field_rotation ftg_field_rotation_i
    (
        .MCLK        (MCLK),
        .reset       (reset),
        .access_type (access_state),
        .rot_count   (rot_count),
        .abs_pos     (abs_pos)
    );

    ftg_cycle_result ftg_cycle_result_i
    (
        .MCLK           (MCLK),
        .reset          (reset),
        .access_type    (access_state),
        .rot_count      (rot_count),
        .bout_cycle_num (bout_cycle_num),
        .bin_clk_en_n   (bin_clk_en_n),
        .bout_clk_en_n  (bout_clk_en_n)
    );

endmodule

/* bubble_timing_gen_asserts.sv */
`timescale 1ns/1ns

module bubble_timing_gen_asserts
(
    input logic MCLK,
    input logic reset,
    input ftg_access_pkg::access_state_t access_type,
    input bubble_timing_pkg::rot_count_t rot_count,
    input bubble_timing_pkg::cycle_num_t bout_cycle_num,
    input logic bin_clk_en_n,
    input logic bout_clk_en_n
);

    import bubble_timing_pkg::*;
    import ftg_access_pkg::*;

    int assert_fails = 0;  // watched from the testbench top

    // bubble-in and bubble-out never share a cycle
    enables_apart: assert property (@(posedge MCLK) disable iff (reset)
        bin_clk_en_n || bout_clk_en_n)
    else
    begin
        $error("bin and bout clock enables low in the same cycle");
        assert_fails++;
    end

    bin_one_cycle: assert property (@(posedge MCLK) disable iff (reset)
        $fell(bin_clk_en_n) |=> bin_clk_en_n)  // single MCLK pulse
    else
    begin
        $error("bin clock enable low for more than one cycle");
        assert_fails++;
    end

    bout_one_cycle: assert property (@(posedge MCLK) disable iff (reset)
        $fell(bout_clk_en_n) |=> bout_clk_en_n)
    else
    begin
        $error("bout clock enable low for more than one cycle");
        assert_fails++;
    end

    // seek and swap move no data, so no bit number at +Y
    no_data_invalid: assert property (@(posedge MCLK) disable iff (reset)
        (rot_count == rot_plus_y && (access_type == idle || access_type == swap))
        |=> bout_cycle_num == cycle_invalid)
    else
    begin
        $error("cycle number not all ones after +Y in seek or swap");
        assert_fails++;
    end

endmodule

bind ftg_cycle_result bubble_timing_gen_asserts bubble_timing_gen_asserts_i (.*);

/* bubble_timing_pkg.sv */
package bubble_timing_pkg;

    // widths that carry a meaning
    typedef logic [3:0]  phase_t;       // divider phase, 0..11
    typedef logic [9:0]  rot_count_t;   // MCLK count within one field rotation
    typedef logic [11:0] abs_pos_t;     // absolute loop position, 0..2052
    typedef logic [12:0] cycle_num_t;   // serial output cycle, all ones = no valid bit
    typedef logic [9:0]  page_count_t;  // page bit counter, 0..583
    typedef logic [6:0]  prop_count_t;  // propagation delay counter, 0..97

    // 48 MHz / 12 -> 4 MHz controller clock
    localparam phase_t divider_last      = 4'd11;
    localparam phase_t clkout_rise_phase = 4'd5;   // clkout goes high after this phase
    localparam phase_t clkout_fall_phase = 4'd11;  // and low after this one

    // controller grid sampling points, three per 4 MHz period
    localparam phase_t sample_phase_a    = 4'd3;
    localparam phase_t sample_phase_b    = 4'd7;
    localparam phase_t sample_phase_c    = 4'd11;

    // field rotation, 480 MCLK per turn once looping
    localparam rot_count_t rot_minus_x   = 10'd208; // rotation may stop here
    localparam rot_count_t rot_plus_y    = 10'd568; // end of turn, loop back
    localparam rot_count_t rot_wrap_to   = 10'd89;
    localparam rot_count_t rot_bin_start = 10'd88;  // first bubble-in point
    localparam rot_count_t rot_bout      = 10'd326; // detector output point, near -Y

    // loop geometry
    localparam abs_pos_t abs_pos_init    = 12'd1951;
    localparam abs_pos_t abs_pos_last    = 12'd2052; // 2053 positions per loop

    // output cycle numbering
    localparam prop_count_t prop_delay_last = 7'd97;   // 98 cycles to the detector
    localparam page_count_t page_last       = 10'd583; // 584 bits per page
    localparam cycle_num_t  bootloop_last   = 13'd4105; // two bootloops interleaved
    localparam cycle_num_t  cycle_invalid   = 13'd8191;
    localparam prop_count_t prop_idle       = 7'd127;  // not counting
    localparam page_count_t page_idle       = 10'd1023;

endpackage

/* ftg_access_decode.sv */
`timescale 1ns/1ns

module ftg_access_decode
(
    input  logic MCLK,
    input  logic reset,
    input  logic sample_strobe,
    input  logic en_n,      // emulator enable
    input  logic bss_n,     // shift start
    input  logic bsen_n,    // shift enable, field rotates while low
    input  logic repen_n,   // replicator enable
    input  logic booten_n,  // bootloop enable
    input  logic swapen_n,  // swap gate enable
    output ftg_access_pkg::access_state_t access_type
);

    import ftg_access_pkg::*;

    ctrl_bits_t    ctrl_raw;    // masked and folded, still asynchronous
    ctrl_bits_t    ctrl_meta;   // first synchronizer stage
    ctrl_bits_t    ctrl_sync;   // second stage
    ctrl_bits_t    ctrl_smp;    // held between sample points
    access_state_t state_next;

    // enable masking
    // repen is forced high while the bootloop is selected, so the page
    // replicator never fires during a bootloop read
    always_comb
    begin
        if (en_n)
            ctrl_raw = ctrl_disabled;
        else
            ctrl_raw = {bss_n, booten_n, bsen_n, repen_n | ~booten_n, swapen_n};
    end

    // two-flop synchronizer, then latch on the controller grid
    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            ctrl_meta <= ctrl_disabled;
            ctrl_sync <= ctrl_disabled;
            ctrl_smp  <= ctrl_disabled;
        end
        else
        begin
            ctrl_meta <= ctrl_raw;
            ctrl_sync <= ctrl_meta;
            if (sample_strobe)
                ctrl_smp <= ctrl_sync;  // phases 3, 7, 11 only
        end
    end

    // access state decode
    always_comb
    begin
        case (ctrl_smp)
            ctrl_rst_boot, ctrl_rst_page:
                // controller idle, standby survives it
                state_next = (access_type == stby) ? stby : rst;
            ctrl_stby_boot, ctrl_stby_page:
                // bss seen
                state_next = (access_type == rst) ? stby : access_type;
            ctrl_boot_read:
            begin
                if (access_type == stby || access_type == boot || access_type == rst)
                    state_next = boot;
                else
                    state_next = access_type;
            end
            ctrl_seek:
                // page seek, also held during a page load
                state_next = (access_type == stby || access_type == rst) ? idle : access_type;
            ctrl_replicate:
                state_next = (access_type == idle) ? user : access_type;
            ctrl_swap:
                state_next = (access_type == idle) ? swap : access_type;
            default:
                state_next = access_type;  // unlisted vectors hold
        endcase
    end

    // state updates the cycle after the latch
    always_ff @(posedge MCLK)
    begin
        if (reset)
            access_type <= rst;
        else
            access_type <= state_next;
    end

endmodule

/* ftg_access_pkg.sv */
package ftg_access_pkg;

    // bit 2 field rotates, bit 1 data moves, bit 0 page instead of bootloop
    typedef enum logic [2:0]
    {
        rst  = 3'b000,
        stby = 3'b001,
        idle = 3'b100,  // page seek
        swap = 3'b101,
        boot = 3'b110,
        user = 3'b111
    } access_state_t;

    // sampled controller strobes, active low: bss, booten, bsen, repen, swapen
    typedef logic [4:0] ctrl_bits_t;

    // what the sampler sees with the emulator disabled
    localparam ctrl_bits_t ctrl_disabled  = 5'b10111;

    // decode table vectors
    localparam ctrl_bits_t ctrl_rst_boot  = 5'b10111; // after power-up or a bootloop read
    localparam ctrl_bits_t ctrl_rst_page  = 5'b11111;
    localparam ctrl_bits_t ctrl_stby_boot = 5'b00111; // bss low, bootloop selected
    localparam ctrl_bits_t ctrl_stby_page = 5'b01111;
    localparam ctrl_bits_t ctrl_boot_read = 5'b10011; // field on, bootloop out
    localparam ctrl_bits_t ctrl_seek      = 5'b11011; // field on, no data
    localparam ctrl_bits_t ctrl_replicate = 5'b11001; // repen pulse
    localparam ctrl_bits_t ctrl_swap      = 5'b11010; // swapen pulse

endpackage

/* ftg_clock_divider.sv */
`timescale 1ns/1ns

module ftg_clock_divider
(
    input  logic MCLK,
    input  logic reset,
    output logic clkout,        // 4 MHz to the bubble memory controller
    output logic sample_strobe  // one MCLK wide, three per clkout period
);

    import bubble_timing_pkg::*;

    phase_t phase;  // 0..11 within one clkout period

    // phase counter and registered clkout
    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            phase  <= '0;
            clkout <= 1'b1;  // comes out of reset high
        end
        else
        begin
            if (phase == divider_last)
                phase <= '0;
            else
                phase <= phase + 4'd1;

            // six cycles high, six low
            if (phase == clkout_rise_phase)
                clkout <= 1'b1;
            else if (phase == clkout_fall_phase)
                clkout <= 1'b0;  // controller launches its strobes here
        end
    end

    // sampling points locked to the controller grid
    // phase 11 coincides with the clkout fall
    assign sample_strobe = (phase == sample_phase_a)
                        || (phase == sample_phase_b)
                        || (phase == sample_phase_c);

endmodule

/* ftg_cycle_result.sv */
`timescale 1ns/1ns

module ftg_cycle_result
(
    input  logic MCLK,
    input  logic reset,
    input  ftg_access_pkg::access_state_t access_type,
    input  bubble_timing_pkg::rot_count_t rot_count,
    output bubble_timing_pkg::cycle_num_t bout_cycle_num,  // serial bit number
    output logic bin_clk_en_n,   // sample write data
    output logic bout_clk_en_n   // launch read data
);

    import bubble_timing_pkg::*;
    import ftg_access_pkg::*;

    prop_count_t prop_cnt;   // bits still travelling to the detector
    page_count_t page_cnt;
    cycle_num_t  boot_cnt;   // runs with the loop, whatever the access
    prop_count_t prop_next;
    page_count_t page_next;
    cycle_num_t  boot_next;
    logic        data_on;    // boot or user
    logic        page_sel;   // user rather than boot
    logic        prop_busy;

    assign data_on  = access_type[1];
    assign page_sel = access_type[0];

    // first 98 updates see an empty track
    assign prop_busy = (prop_cnt == prop_idle) || (prop_cnt < prop_delay_last);

    // next values
    always_comb
    begin
        prop_next = (prop_cnt == prop_idle) ? '0 : prop_cnt + 7'd1;
        page_next = (page_cnt == page_idle) ? '0 : page_cnt + 10'd1;
        boot_next = (boot_cnt == bootloop_last) ? '0 : boot_cnt + 13'd1;
    end

    // cycle numbering
    // updates once per turn at +Y
    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            bout_cycle_num <= cycle_invalid;
            prop_cnt       <= prop_idle;
            page_cnt       <= page_idle;
            boot_cnt       <= cycle_num_t'(abs_pos_init);  // bootloop starts in step
        end
        else if (rot_count == '0)
        begin
            if (access_type == rst)  // field parked and controller reset
            begin
                bout_cycle_num <= cycle_invalid;
                prop_cnt       <= prop_idle;
                page_cnt       <= page_idle;
            end
        end
        else if (rot_count == rot_plus_y)
        begin
            boot_cnt <= boot_next;
            if (!data_on)  // seek or swap, nothing leaves the chip
            begin
                bout_cycle_num <= cycle_invalid;
                prop_cnt       <= prop_idle;
                page_cnt       <= page_idle;
            end
            else if (prop_busy)
            begin
                bout_cycle_num <= cycle_invalid;
                prop_cnt       <= prop_next;
                page_cnt       <= page_idle;
            end
            else if (!page_sel)
            begin
                bout_cycle_num <= boot_next;  // bootloop bits follow the loop
                page_cnt       <= page_idle;
            end
            else if (page_cnt == page_idle || page_cnt < page_last)
            begin
                bout_cycle_num <= cycle_num_t'(page_next);
                page_cnt       <= page_next;
            end
            // page complete, last bit number holds
        end
    end

    // clock enables
    // one MCLK low, registered off the count
    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            bin_clk_en_n  <= 1'b1;
            bout_clk_en_n <= 1'b1;
        end
        else
        begin
            bin_clk_en_n  <= !(rot_count == rot_bin_start || rot_count == rot_plus_y);
            bout_clk_en_n <= !(rot_count == rot_bout);  // detector latch point
        end
    end

endmodule

/* ftg_field_rotation.sv */
`timescale 1ns/1ns

module ftg_field_rotation
(
    input  logic MCLK,
    input  logic reset,
    input  ftg_access_pkg::access_state_t access_type,
    output bubble_timing_pkg::rot_count_t rot_count,  // 0 while parked
    output bubble_timing_pkg::abs_pos_t   abs_pos
);

    import bubble_timing_pkg::*;

    logic field_on;  // access state asks for rotation
    logic at_plus_y;

    assign field_on  = access_type[2];
    assign at_plus_y = (rot_count == rot_plus_y);

    // field rotation counter
    // first turn runs 1..568, every later turn 89..568, i.e. 480 MCLK
    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            rot_count <= '0;
        end
        else if (at_plus_y)
        begin
            rot_count <= rot_wrap_to;  // next turn
        end
        else if ((rot_count == '0 || rot_count == rot_minus_x) && !field_on)
        begin
            rot_count <= '0;  // parked, or stopping at -X
        end
        else
        begin
            rot_count <= rot_count + 10'd1;
        end
    end

    // absolute position
    // one step per turn, taken at +Y
    always_ff @(posedge MCLK)
    begin
        if (reset)
        begin
            abs_pos <= abs_pos_init;
        end
        else if (at_plus_y)
        begin
            if (abs_pos == abs_pos_last)
                abs_pos <= '0;  // 2053 positions per loop
            else
                abs_pos <= abs_pos + 12'd1;
        end
    end

endmodule

/* tb_bubble_timing_gen.sv */
`timescale 1ns/1ns

module tb_bubble_timing_gen;

    import ftg_access_pkg::*;

    localparam int n_random = 12;  // random episodes, two long ones follow
    localparam int n_eps    = n_random + 2;

    logic          MCLK;
    logic          reset;
    logic          en_n, bss_n, bsen_n, repen_n, booten_n, swapen_n;
    logic          clkout;
    access_state_t access_type;
    logic [12:0]   bout_cycle_num;
    logic          bin_clk_en_n;
    logic          bout_clk_en_n;
    logic [11:0]   abs_pos;

    // model, values after the last rising edge
    int            m_phase, m_rot, m_abs;  // divider phase, rotation count, loop position
    int            m_boot, m_cyc, m_prop, m_page;  // m_prop 0 = idle, m_page -1 = idle
    logic          m_clk, m_bin_n, m_bout_n;
    access_state_t m_state;  // decode table fixed point
    access_state_t a_seen;   // access_type ahead of the next edge
    int            stable;   // cycles since the last input change
    int            ep_kind [n_eps];
    int            ep_rots [n_eps];
    logic [31:0]   rng;
    int            cycle_count = 0;
    int            cycle_limit = 0;
    int            i;

    bubble_timing_gen bubble_timing_gen_i
    (
        .MCLK           (MCLK),
        .reset          (reset),
        .en_n           (en_n),
        .bss_n          (bss_n),
        .bsen_n         (bsen_n),
        .repen_n        (repen_n),
        .booten_n       (booten_n),
        .swapen_n       (swapen_n),
        .clkout         (clkout),
        .access_type    (access_type),
        .bout_cycle_num (bout_cycle_num),
        .bin_clk_en_n   (bin_clk_en_n),
        .bout_clk_en_n  (bout_clk_en_n),
        .abs_pos        (abs_pos)
    );

    initial
    begin
        MCLK = 1'b0;
        forever #20 MCLK = ~MCLK;  // 25 MHz in sim, ratios are what count
    end

    always @(posedge MCLK)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("timeout, the episodes did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // access decode table, vector order bss booten bsen repen swapen
    function automatic access_state_t table_next(input access_state_t s, input logic [4:0] v);
        case (v)
            5'b10111, 5'b11111: return (s == stby) ? stby : rst;
            5'b00111, 5'b01111: return (s == rst) ? stby : s;
            5'b10011: return (s == stby || s == boot || s == rst) ? boot : s;
            5'b11011: return (s == stby || s == rst) ? idle : s;
            5'b11001: return (s == idle) ? user : s;
            5'b11010: return (s == idle) ? swap : s;
            default: return s;
        endcase
    endfunction

    function automatic int setup_cycles(input int kind);
        return (kind == 0) ? 32 : (kind == 3) ? 0 : 64;  // short steps before the hold
    endfunction

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("error: %s is %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // advance the model over the edge just passed, then compare
    task step_model_and_check;
        int r;
        r = m_rot;  // count ahead of the edge
        if (m_phase == 5)
            m_clk = 1'b1;
        else if (m_phase == 11)
            m_clk = 1'b0;
        m_phase  = (m_phase == 11) ? 0 : m_phase + 1;
        m_bin_n  = !(r == 88 || r == 568);  // bubble-in at 88 and at +Y
        m_bout_n = !(r == 326);
        if (r == 568)
            m_rot = 89;  // 480 cycle turn
        else if ((r == 0 || r == 208) && !a_seen[2])
            m_rot = 0;   // parked or stopping at -X
        else
            m_rot = r + 1;
        if (r == 0 && a_seen == rst)
        begin
            m_cyc  = 8191;
            m_prop = 0;
            m_page = -1;
        end
        else if (r == 568)
        begin
            m_abs  = (m_abs == 2052) ? 0 : m_abs + 1;
            m_boot = (m_boot == 4105) ? 0 : m_boot + 1;
            if (!a_seen[1])
            begin
                m_cyc  = 8191;  // no data moving
                m_prop = 0;
                m_page = -1;
            end
            else if (m_prop < 98)
            begin
                m_prop++;  // still crossing to the detector
                m_cyc  = 8191;
                m_page = -1;
            end
            else if (!a_seen[0])
            begin
                m_cyc  = m_boot;
                m_page = -1;
            end
            else if (m_page < 583)
            begin
                m_page++;
                m_cyc = m_page;
            end
        end
        stable++;
        compare("clkout", clkout, m_clk);
        compare("bin_clk_en_n", bin_clk_en_n, m_bin_n);
        compare("bout_clk_en_n", bout_clk_en_n, m_bout_n);
        compare("abs_pos", abs_pos, m_abs);
        compare("bout_cycle_num", bout_cycle_num, m_cyc);
        if (stable >= 8)
            compare("access_type", access_type, m_state);
        compare("assertion failures",
                bubble_timing_gen_i.ftg_cycle_result_i.bubble_timing_gen_asserts_i.assert_fails, 0);
        a_seen = access_type;
    endtask

    // drive one input step on the falling edge and hold it
    task apply(input logic en_off, input logic [4:0] v, input int cycles);
        logic [4:0] seen;
        int         n;
        en_n = en_off;
        {bss_n, booten_n, bsen_n, repen_n, swapen_n} = v;
        seen    = en_off ? 5'b10111 : {v[4], v[3], v[2], v[1] | ~v[3], v[0]};  // repen fold
        m_state = table_next(m_state, seen);
        stable  = 0;
        for (n = 0; n < cycles; n++)
        begin
            @(negedge MCLK);
            step_model_and_check();
        end
    endtask

    task run_episode(input int kind, input int rots);
        int hold;
        hold = rots * 480;
        if (setup_cycles(kind) > 0)
            apply(1'b0, 5'b11111, 16);  // release to rst
        case (kind)
            0:
            begin
                apply(1'b0, 5'b00111, 16);    // bss, bootloop selected
                apply(1'b0, 5'b10011, hold);  // bootloop read
            end
            1, 2:
            begin
                apply(1'b0, 5'b01111, 16);  // standby
                apply(1'b0, 5'b11011, 16);  // seek
                apply(1'b0, (kind == 1) ? 5'b11001 : 5'b11010, 16);  // repen or swapen pulse
                apply(1'b0, 5'b11011, hold);
            end
            default:
                apply(1'b1, 5'b11111, hold);  // emulator disabled
        endcase
    endtask

    initial
    begin
        rng = 32'h34c;
        cycle_limit = 16 + 2000;
        for (i = 0; i < n_eps; i++)
        begin
            rng = xorshift(rng);
            ep_kind[i] = (i < n_random) ? rng % 4 : i - n_random;  // long boot, long page
            rng = xorshift(rng);
            ep_rots[i] = (i < n_random) ? 2 + rng % 5 : (i == n_random) ? 104 : 690;
            cycle_limit += setup_cycles(ep_kind[i]) + ep_rots[i] * 480;
        end
        reset = 1'b1;
        {en_n, bss_n, bsen_n, repen_n, booten_n, swapen_n} = '1;
        repeat (16) @(negedge MCLK);
        reset   = 1'b0;
        m_phase = 0;
        m_clk   = 1'b1;
        m_rot   = 0;
        m_abs   = 1951;
        m_boot  = 1951;
        m_cyc   = 8191;
        m_prop  = 0;
        m_page  = -1;
        m_state = rst;
        a_seen  = rst;
        stable  = 100;
        for (i = 0; i < n_eps; i++)
            run_episode(ep_kind[i], ep_rots[i]);
        if (bubble_timing_gen_i.ftg_cycle_result_i.bubble_timing_gen_asserts_i.assert_fails == 0)
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
        else
        begin
            $display("bound assertions flagged a failure");
            abort_run();
        end
    end

endmodule

/* vlog.f */
bubble_timing_pkg.sv
ftg_access_pkg.sv
ftg_clock_divider.sv
ftg_access_decode.sv
ftg_field_rotation.sv
ftg_cycle_result.sv
bubble_timing_gen.sv
bubble_timing_gen_asserts.sv
tb_bubble_timing_gen.sv
